//--- all.f
+incdir+hw
hw/bufPkg.sv
hw/opPkg.sv
hw/ramDualRead.sv
hw/swapMem.sv
hw/bankLoader.sv
hw/rowAlu.sv
hw/swapControl.sv
hw/operandBuffer.sv
sim/operandBufferTb.sv

//--- Bender.yml
package:
  name: operand_buffer

sources:
  - include_dirs:
      - hw
    files:
      - hw/bufPkg.sv
      - hw/opPkg.sv
      - hw/ramDualRead.sv
      - hw/swapMem.sv
      - hw/bankLoader.sv
      - hw/rowAlu.sv
      - hw/swapControl.sv
      - hw/operandBuffer.sv
      - target: simulation
        files:
          - sim/operandBufferTb.sv

//--- sim/operandBufferTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "operandBuffer_defs.svh"

module operandBufferTb import bufPkg::*, opPkg::*; ;

localparam int resetCycles = 8;
localparam int cmdCycles = 5;
localparam int holdCycles = 6;
localparam int releaseCycles = 4;
localparam int numCmds = `BANK_ROWS + 2 * 8 + 2 * 6 + 1 + `BANK_ROWS;
localparam int expectedCycles = resetCycles + 2 * `BANK_ROWS + numCmds * cmdCycles
	+ holdCycles + 2 * releaseCycles;
localparam int cycleLimit = 2 * expectedCycles;

logic   Clock = 1'b0;
logic   rstN, inValid, inReady, cmdValid, cmdReady, resValid, resReady;
logic   relValid, relReady, fillFull;
rowT    inRow, resRow;
opcodeT cmdOp;
addrT   cmdSrcA, cmdSrcB, cmdDst;

int     seed = 37543;
int     errors = 0;
int     checks = 0;
int     cycles = 0;
rowT    bankModel [2][`BANK_ROWS];   // index 0 is bank A.
logic   modelSel;
rowT    batchRows [`BANK_ROWS];

operandBuffer UUT (.*);

always #10 Clock = !Clock;

always @(posedge Clock) begin
	cycles++;
	if (cycles >= cycleLimit) begin
		$display("Timeout: no progress after %0d cycles, checks %0d, errors %0d",
			cycles, checks, errors);
		$display("Simulation FAILED");
		$finish;
	end
end

// ##############################
// reference model.
// ##############################
function automatic rowT expectRow(opcodeT op, rowT a, rowT b);
	logic [`ROW_LANES*`LANE_WIDTH-1:0] flatA, flatB, r;
	longint x, y, m;
	flatA = a;
	flatB = b;
	m = longint'(1) << `LANE_WIDTH;
	for (int i = 0; i < `ROW_LANES; i++) begin
		x = flatA[i*`LANE_WIDTH +: `LANE_WIDTH];
		y = flatB[i*`LANE_WIDTH +: `LANE_WIDTH];
		case (op)
			opPass: r[i*`LANE_WIDTH +: `LANE_WIDTH] = x[`LANE_WIDTH-1:0];
			opAdd:  r[i*`LANE_WIDTH +: `LANE_WIDTH] = (x + y) % m;
			opSub:  r[i*`LANE_WIDTH +: `LANE_WIDTH] = (x + m - y) % m;
			default: r[i*`LANE_WIDTH +: `LANE_WIDTH] = (x >= y) ? x : y;
		endcase
	end
	return r;
endfunction

task automatic compareRow(input string what, input rowT got, input rowT exp);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic compareFlag(input string what, input logic got, input logic exp);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic compareCount(input string what, input int got, input int exp);
	checks++;
	assert (got == exp) else begin
		errors++;
		$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

// ##############################
// stimulus.
// ##############################
task automatic makeBatch();
	for (int i = 0; i < `BANK_ROWS; i++) begin
		batchRows[i] = {$random(seed), $random(seed)};
	end
endtask

task automatic loadBatch();
	for (int i = 0; i < `BANK_ROWS; i++) begin
		inValid = 1'b1;
		inRow = batchRows[i];
		while (!inReady) @(negedge Clock);
		@(negedge Clock);   // taken on the edge between.
		bankModel[modelSel][i] = batchRows[i];
	end
	inValid = 1'b0;
	compareFlag("fillFull after a batch", fillFull, 1'b1);
	compareFlag("inReady after a batch", inReady, 1'b0);
endtask

task automatic releaseBanks();
	int waitCycles;
	waitCycles = 0;
	while (!relReady && waitCycles < releaseCycles) begin
		@(negedge Clock);
		waitCycles++;
	end
	if (!relReady) begin
		errors++;
		$display("Error at %0t: relReady did not rise with a full fill bank", $time);
	end
	relValid = 1'b1;
	while (!relReady) @(negedge Clock);
	@(negedge Clock);
	relValid = 1'b0;
	modelSel = !modelSel;
	compareFlag("fillFull after release", fillFull, 1'b0);
	compareFlag("inReady after release", inReady, 1'b1);
endtask

task automatic runCmd(input opcodeT op, input addrT a, input addrT b, input addrT d,
		input int stall, output rowT got);
	rowT expected;
	rowT held;
	int latency;
	expected = expectRow(op, bankModel[!modelSel][a], bankModel[!modelSel][b]);
	cmdValid = 1'b1;
	cmdOp = op;
	cmdSrcA = a;
	cmdSrcB = b;
	cmdDst = d;
	resReady = (stall == 0);
	while (!cmdReady) @(negedge Clock);
	@(negedge Clock);
	cmdValid = 1'b0;
	latency = 0;
	while (!resValid) begin
		@(negedge Clock);
		latency++;
	end
	if (stall == 0) compareCount("command to result cycles", latency, 2);
	held = resRow;
	for (int i = 0; i < stall; i++) begin
		@(negedge Clock);
		compareRow("resRow under back-pressure", resRow, held);
		compareFlag("cmdReady under back-pressure", cmdReady, 1'b0);
		compareFlag("relReady under back-pressure", relReady, 1'b0);
	end
	resReady = 1'b1;
	compareRow("resRow", resRow, expected);
	got = resRow;
	@(negedge Clock);
	resReady = 1'b0;
	bankModel[!modelSel][d] = expected;   // writeback.
endtask

task automatic randomOps(input int count);
	opcodeT op;
	addrT a, b, d;
	rowT got;
	int pick;
	for (int k = 0; k < count; k++) begin
		pick = $unsigned($random(seed)) % 3;
		op = (pick == 0) ? opAdd : (pick == 1) ? opSub : opMax;
		a = addrT'($random(seed));
		b = addrT'($random(seed));
		d = addrT'($random(seed));
		runCmd(op, a, b, d, 0, got);
		runCmd(opPass, d, d, d, 0, got);   // read the writeback.
	end
endtask

task automatic passAll();
	rowT got;
	for (int i = 0; i < `BANK_ROWS; i++) begin
		runCmd(opPass, addrT'(i), addrT'(i), addrT'(i), 0, got);
		compareRow("pass against loaded row", got, batchRows[i]);
	end
endtask

// ##############################
// protocol checks.
// ##############################
fullBlocksIntake: assert property (@(posedge Clock) disable iff (!rstN)
	fillFull |-> !inReady)
	else begin
		errors++;
		$display("Mismatch at %0t: inReady high while full", $time);
	end

resultHeld: assert property (@(posedge Clock) disable iff (!rstN)
	resValid && !resReady |=> resValid && $stable(resRow))
	else begin
		errors++;
		$display("Mismatch at %0t: result dropped or changed", $time);
	end

busyBlocksRelease: assert property (@(posedge Clock) disable iff (!rstN)
	resValid |-> !cmdReady && !relReady)
	else begin
		errors++;
		$display("Mismatch at %0t: ready high while busy", $time);
	end

releaseNeedsFull: assert property (@(posedge Clock) disable iff (!rstN)
	relReady |-> fillFull)
	else begin
		errors++;
		$display("Mismatch at %0t: relReady without full", $time);
	end

initial begin
	rstN = 1'b0;
	inValid = 1'b0;
	inRow = '0;
	cmdValid = 1'b0;
	cmdOp = opPass;
	cmdSrcA = '0;
	cmdSrcB = '0;
	cmdDst = '0;
	resReady = 1'b0;
	relValid = 1'b0;
	modelSel = 1'b0;
	repeat (resetCycles) @(posedge Clock);
	@(negedge Clock);
	rstN = 1'b1;
	compareFlag("inReady after reset", inReady, 1'b1);
	compareFlag("cmdReady after reset", cmdReady, 1'b1);
	compareFlag("resValid after reset", resValid, 1'b0);
	compareFlag("relReady after reset", relReady, 1'b0);
	compareFlag("fillFull after reset", fillFull, 1'b0);

	makeBatch();
	loadBatch();
	releaseBanks();
	passAll();
	randomOps(8);

	// second batch fills while the ALU works.
	makeBatch();
	fork
		loadBatch();
		randomOps(6);
	join
	begin
		rowT got;
		runCmd(opMax, 4'd1, 4'd2, 4'd3, holdCycles, got);
	end
	releaseBanks();
	passAll();

	$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
	if (errors == 0) begin
		$display("Simulation PASSED");
	end else begin
		$display("Simulation FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

//--- hw/operandBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module operandBuffer import bufPkg::*, opPkg::*; (
	input  logic   Clock,
	input  logic   rstN,
	// row intake.
	input  logic   inValid,
	output logic   inReady,
	input  rowT    inRow,
	// command.
	input  logic   cmdValid,
	output logic   cmdReady,
	input  opcodeT cmdOp,
	input  addrT   cmdSrcA,
	input  addrT   cmdSrcB,
	input  addrT   cmdDst,
	// result.
	output logic   resValid,
	input  logic   resReady,
	output rowT    resRow,
	// release.
	input  logic   relValid,
	output logic   relReady,
	output logic   fillFull
);

logic fillWe;
addrT fillAddr;
rowT  fillData;
addrT workRa0, workRa1;
rowT  workRd0, workRd1;
logic workWe;
addrT workAddr;
rowT  workData;
logic busy;
logic sel;
logic swapPulse;

// ################################
// fill side.
// ################################
bankLoader loader (
	.Clock(Clock), .rstN(rstN),
	.inValid(inValid), .inReady(inReady), .inRow(inRow),
	.swapPulse(swapPulse),
	.fillWe(fillWe), .fillAddr(fillAddr), .fillData(fillData),
	.full(fillFull)
);

// ################################
// work side.
// ################################
rowAlu alu (
	.Clock(Clock), .rstN(rstN),
	.cmdValid(cmdValid), .cmdReady(cmdReady), .cmdOp(cmdOp),
	.cmdSrcA(cmdSrcA), .cmdSrcB(cmdSrcB), .cmdDst(cmdDst),
	.resValid(resValid), .resReady(resReady), .resRow(resRow),
	.workRa0(workRa0), .workRa1(workRa1),
	.workRd0(workRd0), .workRd1(workRd1),
	.workWe(workWe), .workAddr(workAddr), .workData(workData),
	.busy(busy)
);

swapControl swapCtl (
	.Clock(Clock), .rstN(rstN),
	.relValid(relValid), .relReady(relReady),
	.full(fillFull), .busy(busy),
	.sel(sel), .swapPulse(swapPulse)
);

swapMem #(.dataWidth($bits(rowT)), .addrWidth($bits(addrT))) swapMemory (
	.Clock(Clock), .sel(sel),
	.fillWe(fillWe), .fillAddr(fillAddr), .fillData(fillData),
	.workRa0(workRa0), .workRa1(workRa1),
	.workWe(workWe), .workAddr(workAddr), .workData(workData),
	.workRd0(workRd0), .workRd1(workRd1)
);

endmodule

`default_nettype wire

//--- hw/swapControl.sv
`timescale 1ns/1ps
`default_nettype none

module swapControl import bufPkg::*; (
	input  logic Clock,
	input  logic rstN,
	input  logic relValid,
	output logic relReady,
	input  logic full,        // from the loader.
	input  logic busy,        // from the ALU.
	output logic sel,
	output logic swapPulse
);

swapStateT state;

// ################################
// release handshake.
// ################################

// no swap while a command is in flight.
assign relReady = (state == swArmed) && !busy;
assign swapPulse = relValid && relReady;   // handshake edge.

always_ff @(posedge Clock) begin
	if (!rstN) begin
		state <= swFill;
		sel <= 1'b0;   // bank A fills first.
	end else begin
		case (state)
			swFill: begin
				if (full) state <= swArmed;
			end
			swArmed: begin
				if (swapPulse) begin
					sel <= !sel;
					state <= swFill;
				end
			end
			default: state <= swFill;
		endcase
	end
end

// ################################
// checks.
// ################################
selOnRelease: assert property (
	@(posedge Clock) disable iff (!rstN)
	!swapPulse |=> $stable(sel)
) else $error("sel changed without a release handshake");

// loader and controller agree the fill bank is complete.
swapOnlyFull: assert property (
	@(posedge Clock) disable iff (!rstN)
	swapPulse |-> full
) else $error("release granted before the fill bank was full");

endmodule

`default_nettype wire

//--- hw/rowAlu.sv
`timescale 1ns/1ps
`default_nettype none
`include "operandBuffer_defs.svh"

module rowAlu import bufPkg::*, opPkg::*; (
	input  logic   Clock,
	input  logic   rstN,
	input  logic   cmdValid,
	output logic   cmdReady,
	input  opcodeT cmdOp,
	input  addrT   cmdSrcA,
	input  addrT   cmdSrcB,
	input  addrT   cmdDst,
	output logic   resValid,
	input  logic   resReady,
	output rowT    resRow,
	output addrT   workRa0,
	output addrT   workRa1,
	input  rowT    workRd0,
	input  rowT    workRd1,
	output logic   workWe,
	output addrT   workAddr,
	output rowT    workData,
	output logic   busy
);

aluStateT state;
logic     readDone;   // read data registered, second exec cycle.
opcodeT   opReg;
addrT     dstReg;
rowT      aluOut;

// ################################
// lane datapath.
// ################################
function automatic rowT laneOp(opcodeT op, rowT a, rowT b);
	rowT r;
	for (int i = 0; i < `ROW_LANES; i++) begin
		case (op)
			opPass: r[i] = a[i];
			opAdd:  r[i] = a[i] + b[i];
			opSub:  r[i] = a[i] - b[i];
			default: r[i] = (a[i] > b[i]) ? a[i] : b[i];   // opMax.
		endcase
	end
	return r;
endfunction

assign aluOut = laneOp(opReg, workRd0, workRd1);

assign cmdReady = (state == aluIdle);
assign busy = (state != aluIdle);
assign resValid = (state == aluHold);

// single writeback per command.
assign workWe = (state == aluExec) && readDone;
assign workAddr = dstReg;
assign workData = aluOut;

// ################################
// FSM.
// ################################
always_ff @(posedge Clock) begin
	if (!rstN) begin
		state <= aluIdle;
		readDone <= 1'b0;
	end else begin
		case (state)
			aluIdle: begin
				readDone <= 1'b0;
				if (cmdValid) state <= aluExec;
			end
			aluExec: begin
				readDone <= 1'b1;
				if (readDone) state <= aluHold;
			end
			aluHold: if (resReady) state <= aluIdle;
			default: state <= aluIdle;
		endcase
	end
end

// command and result payload.
always_ff @(posedge Clock) begin
	if (cmdValid && cmdReady) begin
		opReg <= cmdOp;
		workRa0 <= cmdSrcA;   // addresses reach the bank this cycle.
		workRa1 <= cmdSrcB;
		dstReg <= cmdDst;
	end
	if (workWe) resRow <= aluOut;
end

resStable: assert property (
	@(posedge Clock) disable iff (!rstN)
	resValid && !resReady |=> resValid && $stable(resRow)
) else $error("resRow changed under back-pressure");

cmdToRes: assert property (
	@(posedge Clock) disable iff (!rstN)
	cmdValid && cmdReady |=> !resValid ##1 !resValid ##1 resValid
) else $error("result not two cycles after command");

endmodule

`default_nettype wire

//--- hw/bankLoader.sv
`timescale 1ns/1ps
`default_nettype none
`include "operandBuffer_defs.svh"

module bankLoader import bufPkg::*; (
	input  logic Clock,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  rowT  inRow,
	input  logic swapPulse,
	output logic fillWe,
	output addrT fillAddr,
	output rowT  fillData,
	output logic full
);

addrT count;   // next fill address.
logic accept;

assign inReady = !full;
assign accept = inValid && inReady;

// rows go straight into the fill bank.
assign fillWe = accept;
assign fillAddr = count;
assign fillData = inRow;

// ################################
// row count and full flag.
// ################################
always_ff @(posedge Clock) begin
	if (!rstN) begin
		count <= '0;
		full <= 1'b0;
	end else if (swapPulse) begin
		count <= '0;
		full <= 1'b0;
	end else if (accept) begin
		count <= count + addrT'(1);
		if (count == addrT'(`BANK_ROWS - 1)) begin
			full <= 1'b1;   // last row of the bank.
		end
	end
end

// once full, the bank stays untouched until the swap.
noWriteWhileFull: assert property (
	@(posedge Clock) disable iff (!rstN)
	$rose(full) |-> !fillWe throughout swapPulse[->1]
) else $error("fill write while the bank is full");

endmodule

`default_nettype wire

//--- hw/swapMem.sv
`timescale 1ns/1ps
`default_nettype none
`include "operandBuffer_defs.svh"

module swapMem #(
	parameter int dataWidth = `ROW_LANES * `LANE_WIDTH,
	parameter int addrWidth = `ADDR_WIDTH,
	parameter int memSize = `BANK_ROWS
) (
	input  logic                 Clock,
	input  logic                 sel,       // 0: A fills, B works.
	input  logic                 fillWe,
	input  logic [addrWidth-1:0] fillAddr,
	input  logic [dataWidth-1:0] fillData,
	input  logic [addrWidth-1:0] workRa0,
	input  logic [addrWidth-1:0] workRa1,
	input  logic                 workWe,
	input  logic [addrWidth-1:0] workAddr,
	input  logic [dataWidth-1:0] workData,
	output logic [dataWidth-1:0] workRd0,
	output logic [dataWidth-1:0] workRd1
);

logic                 weA, weB;
logic [addrWidth-1:0] waA, waB;
logic [dataWidth-1:0] wdA, wdB;
logic [addrWidth-1:0] raA0, raA1, raB0, raB1;
logic [dataWidth-1:0] rdA0, rdA1, rdB0, rdB1;

// ################################
// crossing muxes.
// ################################
assign weA = sel ? workWe : fillWe;
assign weB = sel ? fillWe : workWe;
assign waA = sel ? workAddr : fillAddr;
assign waB = sel ? fillAddr : workAddr;
assign wdA = sel ? workData : fillData;
assign wdB = sel ? fillData : workData;

// fill side never reads.
assign raA0 = sel ? workRa0 : '0;
assign raA1 = sel ? workRa1 : '0;
assign raB0 = sel ? '0 : workRa0;
assign raB1 = sel ? '0 : workRa1;

assign workRd0 = sel ? rdA0 : rdB0;
assign workRd1 = sel ? rdA1 : rdB1;

ramDualRead #(.dataWidth(dataWidth), .addrWidth(addrWidth), .memSize(memSize)) bankA (
	.Clock(Clock), .we(weA), .wrAddr(waA), .wrData(wdA),
	.rdAddr0(raA0), .rdAddr1(raA1), .rdData0(rdA0), .rdData1(rdA1)
);

ramDualRead #(.dataWidth(dataWidth), .addrWidth(addrWidth), .memSize(memSize)) bankB (
	.Clock(Clock), .we(weB), .wrAddr(waB), .wrData(wdB),
	.rdAddr0(raB0), .rdAddr1(raB1), .rdData0(rdB0), .rdData1(rdB1)
);

// a fill write on the swap edge would land in the new work bank.
fillVsSwap: assert property (@(posedge Clock) $past(fillWe) |-> $stable(sel))
	else $error("fill write collided with a bank swap");

endmodule

`default_nettype wire

//--- hw/ramDualRead.sv
`timescale 1ns/1ps
`default_nettype none
`include "operandBuffer_defs.svh"

module ramDualRead #(
	parameter int dataWidth = `ROW_LANES * `LANE_WIDTH,
	parameter int addrWidth = `ADDR_WIDTH,
	parameter int memSize = `BANK_ROWS
) (
	input  logic                 Clock,
	input  logic                 we,
	input  logic [addrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0] wrData,
	input  logic [addrWidth-1:0] rdAddr0,
	input  logic [addrWidth-1:0] rdAddr1,
	output logic [dataWidth-1:0] rdData0,
	output logic [dataWidth-1:0] rdData1
);

logic [dataWidth-1:0] mem [memSize];

// write and both reads share the edge, reads see the old row.
always_ff @(posedge Clock) begin
	if (we) begin
		mem[wrAddr] <= wrData;
	end
	rdData0 <= mem[rdAddr0];
	rdData1 <= mem[rdAddr1];
end

endmodule

`default_nettype wire

//--- hw/opPkg.sv
`default_nettype none

package opPkg;

	// ################################
	// row ALU operations.
	// ################################
	typedef enum logic [1:0] {
		opPass = 2'd0,  // copy row A.
		opAdd  = 2'd1,  // lane sum, wraps.
		opSub  = 2'd2,  // lane difference, wraps.
		opMax  = 2'd3   // unsigned lane max.
	} opcodeT;

	// ################################
	// row ALU sequencing.
	// ################################
	typedef enum logic [1:0] {
		aluIdle = 2'd0,
		aluExec = 2'd1,   // read, then compute and write back.
		aluHold = 2'd2    // result waits for resReady.
	} aluStateT;

endpackage

`default_nettype wire

//--- hw/bufPkg.sv
`default_nettype none
`include "operandBuffer_defs.svh"

package bufPkg;

	// one row, lane 0 in the low bits.
	typedef logic [`ROW_LANES-1:0][`LANE_WIDTH-1:0] rowT;

	// row address inside one bank.
	typedef logic [`ADDR_WIDTH-1:0] addrT;

	// swap controller.
	typedef enum logic {
		swFill,   // fill bank still loading.
		swArmed   // fill bank full, waiting for release.
	} swapStateT;

endpackage

`default_nettype wire

//--- hw/operandBuffer_defs.svh
`ifndef OPERANDBUFFER_DEFS_SVH
`define OPERANDBUFFER_DEFS_SVH

// ################################
// row geometry.
// ################################
`define LANE_WIDTH 16
`define ROW_LANES 4

// ################################
// bank geometry.
// ################################
`define BANK_ROWS 16
`define ADDR_WIDTH 4

`endif
